// File: design/branch_unit.sv
// --------------------
// Per-thread branch tables and next-counter selection. The issuing thread's
// entries are matched against its counter and previous-result flags.
// --------------------
`default_nettype none

module branch_unit
    import ctrl_pkg::*;
(
    input  wire logic                         clock,
    input  wire logic                         rst_n,
    input  wire logic [THREAD_WIDTH-1:0]      issue_thread,
    input  wire logic [PC_WIDTH-1:0]          pc,
    input  wire logic                         bt_write,
    input  wire logic [WRITE_INDEX_WIDTH-1:0] write_index,
    input  wire logic [WORD_WIDTH-1:0]        write_data,
    input  wire logic                         carryout,
    input  wire logic                         overflow,
    input  wire logic                         a_external,
    input  wire logic                         b_external,
    input  wire logic [WORD_WIDTH-1:0]        r_previous,
    output logic [PC_WIDTH-1:0]               next_pc,
    output logic                              take_cancel
);

    localparam int COND_COUNT = 8;

    branch_entry_t branch_table [THREAD_COUNT][BRANCH_COUNT];

    // --------------------
    // Table storage
    // --------------------

    logic [THREAD_WIDTH-1:0] wr_thread;
    logic [BRANCH_WIDTH-1:0] wr_entry;

    // Table index is thread times four plus entry
    assign wr_thread = write_index[BT_INDEX_WIDTH-1:BRANCH_WIDTH];
    assign wr_entry  = write_index[BRANCH_WIDTH-1:0];

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            for (int t = 0; t < THREAD_COUNT; t++) begin
                for (int e = 0; e < BRANCH_COUNT; e++) begin
                    branch_table[t][e] <= '0;
                end
            end
        end else if (bt_write) begin
            branch_table[wr_thread][wr_entry] <=
                branch_entry_t'(write_data[$bits(branch_entry_t)-1:0]);
        end
    end

    // --------------------
    // Flags
    // --------------------

    logic                  zero;
    logic                  negative;
    logic                  lessthan;
    logic [COND_COUNT-1:0] cond_true;

    assign zero     = (r_previous == '0);
    assign negative = r_previous[WORD_WIDTH-1];
    assign lessthan = overflow ^ negative;

    // One bit per condition code, indexed by cond_e
    always_comb begin
        cond_true                  = '0;
        cond_true[COND_ALWAYS]     = 1'b1;
        cond_true[COND_ZERO]       = zero;
        cond_true[COND_NONZERO]    = !zero;
        cond_true[COND_NEGATIVE]   = negative;
        cond_true[COND_CARRY]      = carryout;
        cond_true[COND_LESSTHAN]   = lessthan;
        cond_true[COND_A_EXTERNAL] = a_external;
        cond_true[COND_B_EXTERNAL] = b_external;
    end

    // --------------------
    // Entry match and priority
    // --------------------

    logic [BRANCH_COUNT-1:0] match;

    always_comb begin
        for (int e = 0; e < BRANCH_COUNT; e++) begin
            match[e] = branch_table[issue_thread][e].enable
                       && (branch_table[issue_thread][e].origin == pc)
                       && cond_true[branch_table[issue_thread][e].cond];
        end
    end

    // Lowest-index match wins
    always_comb begin
        logic taken;
        taken       = 1'b0;
        next_pc     = pc + 1'b1;
        take_cancel = 1'b0;
        for (int e = 0; e < BRANCH_COUNT; e++) begin
            if (!taken && match[e]) begin
                taken       = 1'b1;
                next_pc     = branch_table[issue_thread][e].dest;
                take_cancel = branch_table[issue_thread][e].cancel;
            end
        end
    end

endmodule

`default_nettype wire

// File: design/control_path.sv
// --------------------
// Top of the barrel control path. Connects scheduler, counters, branch
// tables and fetch/decode, and carries the config write port.
// --------------------
`default_nettype none

module control_path
    import ctrl_pkg::*;
(
    input  wire logic                         clock,
    input  wire logic                         rst_n,
    input  wire logic                         run,
    input  wire logic                         config_write,
    input  wire logic [CONFIG_ADDR_WIDTH-1:0] config_addr,
    input  wire logic [WORD_WIDTH-1:0]        config_data,
    input  wire logic                         carryout,
    input  wire logic                         overflow,
    input  wire logic                         a_external,
    input  wire logic                         b_external,
    input  wire logic [WORD_WIDTH-1:0]        r_previous,
    output logic                              out_valid,
    output logic [THREAD_WIDTH-1:0]           out_thread,
    output logic                              cancel,
    output alu_ctrl_t                         alu_control,
    output logic [D_OPERAND_WIDTH-1:0]        dst,
    output logic [A_OPERAND_WIDTH-1:0]        src_a,
    output logic [B_OPERAND_WIDTH-1:0]        src_b
);

    logic                                     issue_valid;
    logic [THREAD_WIDTH-1:0]                  issue_thread;
    logic [STAGE_COUNT-1:0]                   stage_valid;
    logic [STAGE_COUNT-1:0][THREAD_WIDTH-1:0] stage_thread;
    logic                                     im_write;
    logic                                     od_write;
    logic                                     bt_write;
    logic [WRITE_INDEX_WIDTH-1:0]             write_index;
    logic [WORD_WIDTH-1:0]                    write_data;
    logic [PC_WIDTH-1:0]                      pc;
    logic [PC_WIDTH-1:0]                      next_pc;
    logic                                     take_cancel;

    thread_scheduler u_scheduler (
        .clock, .rst_n, .run, .config_write, .config_addr, .config_data,
        .issue_valid, .issue_thread, .stage_valid, .stage_thread,
        .im_write, .od_write, .bt_write, .write_index, .write_data
    );

    pc_unit u_pc (
        .clock, .rst_n, .issue_valid, .issue_thread, .next_pc, .pc
    );

    branch_unit u_branch (
        .clock, .rst_n, .issue_thread, .pc, .bt_write, .write_index, .write_data,
        .carryout, .overflow, .a_external, .b_external, .r_previous,
        .next_pc, .take_cancel
    );

    fetch_decode u_fetch (
        .clock, .rst_n, .issue_valid, .issue_thread, .pc, .take_cancel,
        .stage_valid, .stage_thread, .im_write, .od_write, .write_index, .write_data,
        .out_valid, .out_thread, .cancel, .alu_control, .dst, .src_a, .src_b
    );

endmodule

`default_nettype wire

// File: design/ctrl_pkg.sv
// --------------------
// Shared widths, address map and field layouts of the barrel control path.
// Imported by every RTL module and by the testbench.
// --------------------
`default_nettype none

package ctrl_pkg;

    // Threads and pipeline
    localparam int THREAD_COUNT    = 4;
    localparam int THREAD_WIDTH    = 2;
    localparam int STAGE_COUNT     = 3;
    localparam int PC_WIDTH        = 6;
    localparam int PC_START_STRIDE = 16;

    // Word and instruction format
    localparam int WORD_WIDTH        = 32;
    localparam int CONFIG_ADDR_WIDTH = 10;
    localparam int OPCODE_WIDTH      = 4;
    localparam int D_OPERAND_WIDTH   = 10;
    localparam int A_OPERAND_WIDTH   = 9;
    localparam int B_OPERAND_WIDTH   = 9;
    localparam int ALU_CTRL_WIDTH    = 12;

    // Branch tables
    localparam int BRANCH_COUNT = 4;
    localparam int BRANCH_WIDTH = 2;

    // --------------------
    // Config address map, each region aligned to its size
    localparam logic [CONFIG_ADDR_WIDTH-1:0] IM_BASE = 10'h000;
    localparam logic [CONFIG_ADDR_WIDTH-1:0] OD_BASE = 10'h100;
    localparam logic [CONFIG_ADDR_WIDTH-1:0] BT_BASE = 10'h200;

    localparam int IM_DEPTH          = 64;
    localparam int OD_DEPTH          = 64;
    localparam int BT_DEPTH          = 16;
    localparam int IM_INDEX_WIDTH    = 6;
    localparam int OD_INDEX_WIDTH    = 6;
    localparam int BT_INDEX_WIDTH    = 4;
    localparam int WRITE_INDEX_WIDTH = 6;

    // --------------------
    typedef struct packed {
        logic [OPCODE_WIDTH-1:0]    opcode;
        logic [D_OPERAND_WIDTH-1:0] d;
        logic [A_OPERAND_WIDTH-1:0] a;
        logic [B_OPERAND_WIDTH-1:0] b;
    } instr_t;

    typedef logic [ALU_CTRL_WIDTH-1:0] alu_ctrl_t;

    typedef enum logic [2:0] {
        COND_ALWAYS,
        COND_ZERO,
        COND_NONZERO,
        COND_NEGATIVE,
        COND_CARRY,
        COND_LESSTHAN,
        COND_A_EXTERNAL,
        COND_B_EXTERNAL
    } cond_e;

    // Sits in the low 17 bits of a config word
    typedef struct packed {
        logic                enable;
        logic                cancel;
        cond_e               cond;
        logic [PC_WIDTH-1:0] origin;
        logic [PC_WIDTH-1:0] dest;
    } branch_entry_t;

endpackage

`default_nettype wire

// File: design/fetch_decode.sv
// --------------------
// Instruction fetch from the shared memory, per-thread opcode decode and
// output registers. Outputs appear three cycles after issue.
// --------------------
`default_nettype none

module fetch_decode
    import ctrl_pkg::*;
(
    input  wire logic                                clock,
    input  wire logic                                rst_n,
    input  wire logic                                issue_valid,
    input  wire logic [THREAD_WIDTH-1:0]             issue_thread,
    input  wire logic [PC_WIDTH-1:0]                 pc,
    input  wire logic                                take_cancel,
    input  wire logic [STAGE_COUNT-1:0]              stage_valid,
    input  wire logic [STAGE_COUNT-1:0][THREAD_WIDTH-1:0] stage_thread,
    input  wire logic                                im_write,
    input  wire logic                                od_write,
    input  wire logic [WRITE_INDEX_WIDTH-1:0]        write_index,
    input  wire logic [WORD_WIDTH-1:0]               write_data,
    output logic                                     out_valid,
    output logic [THREAD_WIDTH-1:0]                  out_thread,
    output logic                                     cancel,
    output alu_ctrl_t                                alu_control,
    output logic [D_OPERAND_WIDTH-1:0]               dst,
    output logic [A_OPERAND_WIDTH-1:0]               src_a,
    output logic [B_OPERAND_WIDTH-1:0]               src_b
);

    instr_t                     instr;
    alu_ctrl_t                  od_word;
    logic [D_OPERAND_WIDTH-1:0] dst_q;
    logic [A_OPERAND_WIDTH-1:0] src_a_q;
    logic [B_OPERAND_WIDTH-1:0] src_b_q;
    logic [THREAD_COUNT-1:0]    cancel_pending;

    // N+1: instruction at the old counter
    sync_ram #(.entry_t(instr_t), .DEPTH(IM_DEPTH)) im_ram (
        .clock       (clock),
        .write       (im_write),
        .write_index (write_index[IM_INDEX_WIDTH-1:0]),
        .write_data  (instr_t'(write_data)),
        .read_index  (pc),
        .read_data   (instr)
    );

    // N+2: decoder word for this thread and opcode
    sync_ram #(.entry_t(alu_ctrl_t), .DEPTH(OD_DEPTH)) od_ram (
        .clock       (clock),
        .write       (od_write),
        .write_index (write_index[OD_INDEX_WIDTH-1:0]),
        .write_data  (alu_ctrl_t'(write_data[ALU_CTRL_WIDTH-1:0])),
        .read_index  ({stage_thread[0], instr.opcode}),
        .read_data   (od_word)
    );

    // A thread comes round only every fourth cycle, so one flag per
    // thread is enough to carry the cancel until its output stage
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            cancel_pending <= '0;
            cancel         <= 1'b0;
        end else begin
            if (issue_valid) begin
                cancel_pending[issue_thread] <= take_cancel;
            end
            cancel <= stage_valid[1] && cancel_pending[stage_thread[1]];
        end
    end

    // Operands wait one cycle for the decoder read
    always_ff @(posedge clock) begin
        if (stage_valid[0]) begin
            dst_q   <= instr.d;
            src_a_q <= instr.a;
            src_b_q <= instr.b;
        end
        if (stage_valid[1]) begin
            alu_control <= od_word;
            dst         <= dst_q;
            src_a       <= src_a_q;
            src_b       <= src_b_q;
        end
    end

    // Last tag stage already sits at N+3
    assign out_valid  = stage_valid[2];
    assign out_thread = stage_thread[2];

endmodule

`default_nettype wire

// File: design/pc_unit.sv
// --------------------
// One program counter per thread. The issuing thread's counter is read
// combinationally and replaced by next_pc at the end of its issue cycle.
// --------------------
`default_nettype none

module pc_unit
    import ctrl_pkg::*;
(
    input  wire logic                    clock,
    input  wire logic                    rst_n,
    input  wire logic                    issue_valid,
    input  wire logic [THREAD_WIDTH-1:0] issue_thread,
    input  wire logic [PC_WIDTH-1:0]     next_pc,
    output logic [PC_WIDTH-1:0]          pc
);

    logic [PC_WIDTH-1:0] pc_reg [THREAD_COUNT];

    // Each thread starts at the base of its own slice of the memory
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            for (int t = 0; t < THREAD_COUNT; t++) begin
                pc_reg[t] <= PC_WIDTH'(t * PC_START_STRIDE);
            end
        end else if (issue_valid) begin
            pc_reg[issue_thread] <= next_pc;
        end
    end

    assign pc = pc_reg[issue_thread];

endmodule

`default_nettype wire

// File: design/sync_ram.sv
// --------------------
// Synchronous memory, one write port and one registered read port.
// Returns the old word when read and write hit the same entry.
// --------------------
`default_nettype none

module sync_ram #(
    parameter type entry_t = logic [7:0],
    parameter int  DEPTH   = 64
) (
    input  wire logic                     clock,
    input  wire logic                     write,
    input  wire logic [$clog2(DEPTH)-1:0] write_index,
    input  wire entry_t                   write_data,
    input  wire logic [$clog2(DEPTH)-1:0] read_index,
    output entry_t                        read_data
);

    entry_t mem [DEPTH];

    // Write port
    always_ff @(posedge clock) begin
        if (write) begin
            mem[write_index] <= write_data;
        end
    end

    // Read port, samples the array before this edge's write lands
    always_ff @(posedge clock) begin
        read_data <= mem[read_index];
    end

endmodule

`default_nettype wire

// File: design/thread_scheduler.sv
// --------------------
// Round-robin issue of the four threads, the valid/thread tags that follow
// each issue down the pipeline, and config address decode into table strobes.
// --------------------
`default_nettype none

module thread_scheduler
    import ctrl_pkg::*;
(
    input  wire logic                                     clock,
    input  wire logic                                     rst_n,
    input  wire logic                                     run,
    input  wire logic                                     config_write,
    input  wire logic [CONFIG_ADDR_WIDTH-1:0]             config_addr,
    input  wire logic [WORD_WIDTH-1:0]                    config_data,
    output logic                                          issue_valid,
    output logic [THREAD_WIDTH-1:0]                       issue_thread,
    output logic [STAGE_COUNT-1:0]                        stage_valid,
    output logic [STAGE_COUNT-1:0][THREAD_WIDTH-1:0]      stage_thread,
    output logic                                          im_write,
    output logic                                          od_write,
    output logic                                          bt_write,
    output logic [WRITE_INDEX_WIDTH-1:0]                  write_index,
    output logic [WORD_WIDTH-1:0]                         write_data
);

    logic [THREAD_WIDTH-1:0] thread_ptr;

    // --------------------
    // Issue
    // --------------------

    // A barrel never stalls, so every run cycle issues
    assign issue_valid  = run;
    assign issue_thread = thread_ptr;

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            thread_ptr   <= '0;
            stage_valid  <= '0;
            stage_thread <= '0;
        end else begin
            if (run) begin
                thread_ptr <= thread_ptr + 1'b1;
            end
            // Stage 0 is N+1, last stage lines up with the outputs
            stage_valid  <= {stage_valid[STAGE_COUNT-2:0], issue_valid};
            stage_thread <= {stage_thread[STAGE_COUNT-2:0], thread_ptr};
        end
    end

    // --------------------
    // Config decode
    // --------------------

    logic im_hit;
    logic od_hit;
    logic bt_hit;

    // Regions are size-aligned, so the upper bits pick the region
    assign im_hit = config_addr[CONFIG_ADDR_WIDTH-1:IM_INDEX_WIDTH]
                    == IM_BASE[CONFIG_ADDR_WIDTH-1:IM_INDEX_WIDTH];
    assign od_hit = config_addr[CONFIG_ADDR_WIDTH-1:OD_INDEX_WIDTH]
                    == OD_BASE[CONFIG_ADDR_WIDTH-1:OD_INDEX_WIDTH];
    assign bt_hit = config_addr[CONFIG_ADDR_WIDTH-1:BT_INDEX_WIDTH]
                    == BT_BASE[CONFIG_ADDR_WIDTH-1:BT_INDEX_WIDTH];

    assign im_write = config_write && im_hit;
    assign od_write = config_write && od_hit;
    assign bt_write = config_write && bt_hit;

    // Offset inside the region, narrower regions use the low bits only
    assign write_index = config_addr[WRITE_INDEX_WIDTH-1:0];
    assign write_data  = config_data;

endmodule

`default_nettype wire

// File: sources.f
design/ctrl_pkg.sv
design/sync_ram.sv
design/thread_scheduler.sv
design/pc_unit.sv
design/branch_unit.sv
design/fetch_decode.sv
design/control_path.sv
testbench/control_path_sva.sv
testbench/control_path_tb.sv

// File: testbench/control_path_sva.sv
// --------------------
// Reset and output protocol assertions on the control path top level.
// Attached by the bind at the end of this file.
// --------------------
`default_nettype none

module control_path_sva
    import ctrl_pkg::*;
(
    input wire logic                    clock,
    input wire logic                    rst_n,
    input wire logic                    issue_valid,
    input wire logic [THREAD_WIDTH-1:0] issue_thread,
    input wire logic                    out_valid,
    input wire logic [THREAD_WIDTH-1:0] out_thread,
    input wire logic                    cancel
);
    timeunit 1ns;
    timeprecision 100ps;

    int failures = 0;

    // Pipeline is empty for three cycles after reset release
    reset_quiet: assert property (@(posedge clock)
        $rose(rst_n) |-> (!out_valid && !cancel) [*3])
    else begin
        failures++;
        $error("outputs active within three cycles of reset release");
    end

    valid_follows_issue: assert property (@(posedge clock) disable iff (!rst_n)
        out_valid |-> $past(issue_valid, 3) && out_thread == $past(issue_thread, 3))
    else begin
        failures++;
        $error("output valid without an issue of that thread three cycles before");
    end

endmodule

bind control_path control_path_sva u_checks (
    .clock        (clock),
    .rst_n        (rst_n),
    .issue_valid  (issue_valid),
    .issue_thread (issue_thread),
    .out_valid    (out_valid),
    .out_thread   (out_thread),
    .cancel       (cancel)
);

`default_nettype wire

// File: testbench/control_path_tb.sv
// --------------------
// Testbench for the barrel control path. Loads the tables over the config
// port, runs random flags and checks every output against a shadow model.
// --------------------
`default_nettype none

module control_path_tb
    import ctrl_pkg::*;
;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int DRAIN_LIMIT = 32;

    typedef struct packed {
        logic [1:0]  thread;
        logic        cancel;
        logic [11:0] alu;
        logic [9:0]  d;
        logic [8:0]  a;
        logic [8:0]  b;
    } expect_t;

    logic        clock = 1'b0;
    logic        rst_n;
    logic        run;
    logic        config_write;
    logic [9:0]  config_addr;
    logic [31:0] config_data;
    logic        carryout;
    logic        overflow;
    logic        a_external;
    logic        b_external;
    logic [31:0] r_previous;
    logic        out_valid;
    logic [1:0]  out_thread;
    logic        cancel;
    alu_ctrl_t   alu_control;
    logic [9:0]  dst;
    logic [8:0]  src_a;
    logic [8:0]  src_b;

    // Shadow state of the reference model
    logic [31:0] im_m [64];
    logic [11:0] od_m [64];
    logic [16:0] bt_m [16];
    logic [5:0]  pc_m [4];
    logic [1:0]  ptr_m;
    expect_t     expected [$];
    int          compared = 0;

    control_path dut (
        .clock, .rst_n, .run, .config_write, .config_addr, .config_data,
        .carryout, .overflow, .a_external, .b_external, .r_previous,
        .out_valid, .out_thread, .cancel, .alu_control, .dst, .src_a, .src_b
    );

    always #2 clock = ~clock;

    // --------------------
    // Helpers
    // --------------------

    task automatic fail_with(input string msg);
        $display("%s", msg);
        $display("Checks failed");
        $fatal(1);
    endtask

    task automatic mismatch(input string name, input logic [31:0] got, input logic [31:0] want);
        fail_with($sformatf("Mismatch %s: got %h expected %h", name, got, want));
    endtask

    // One clock edge with fresh random flags, config write dropped
    task automatic tick();
        @(posedge clock);
        carryout     <= 1'($urandom);
        overflow     <= 1'($urandom);
        a_external   <= 1'($urandom);
        b_external   <= 1'($urandom);
        r_previous   <= ($urandom_range(3) == 0) ? 32'h0 : 32'($urandom);
        config_write <= 1'b0;
    endtask

    task automatic write_config(input int addr, input logic [31:0] data);
        tick();
        config_write <= 1'b1;
        config_addr  <= 10'(addr);
        config_data  <= data;
    endtask

    // Entry layout: enable, cancel, condition, origin, destination
    function automatic logic [31:0] branch_word(input logic en, input logic cn,
                                                input int cond, input int origin,
                                                input int dest);
        return {15'h0, en, cn, 3'(cond), 6'(origin), 6'(dest)};
    endfunction

    // Reference branch decision, returns {cancel, next counter}
    function automatic logic [6:0] next_counter(input logic [1:0] thread, input logic [5:0] pc,
                                                input logic c, input logic v,
                                                input logic ax, input logic bx,
                                                input logic [31:0] r);
        logic [16:0] entry;
        logic        holds;
        logic        zero;
        logic        neg;
        next_counter = {1'b0, pc + 6'd1};
        zero = (r == 32'h0);
        neg  = r[31];
        // Walk down so the lowest matching entry is applied last
        for (int e = 3; e >= 0; e--) begin
            entry = bt_m[thread * 4 + e];
            case (entry[14:12])
                3'd0:    holds = 1'b1;
                3'd1:    holds = zero;
                3'd2:    holds = !zero;
                3'd3:    holds = neg;
                3'd4:    holds = c;
                3'd5:    holds = v ^ neg;
                3'd6:    holds = ax;
                default: holds = bx;
            endcase
            if (entry[16] && entry[11:6] == pc && holds) begin
                next_counter = {entry[15], entry[5:0]};
            end
        end
    endfunction

    // --------------------
    // Reference model, issue first, then this edge's config write
    // --------------------
    always @(posedge clock) begin
        expect_t     e;
        logic [6:0]  br;
        logic [5:0]  cur;
        logic [31:0] word;
        if (!rst_n) begin
            ptr_m = 2'd0;
            for (int t = 0; t < 4; t++) begin
                pc_m[t] = 6'(t * 16);
            end
            for (int i = 0; i < 16; i++) begin
                bt_m[i] = 17'h0;
            end
        end else begin
            if (run) begin
                cur      = pc_m[ptr_m];
                br       = next_counter(ptr_m, cur, carryout, overflow, a_external,
                                        b_external, r_previous);
                word     = im_m[cur];
                e.thread = ptr_m;
                e.cancel = br[6];
                e.alu    = od_m[{ptr_m, word[31:28]}];
                e.d      = word[27:18];
                e.a      = word[17:9];
                e.b      = word[8:0];
                expected.push_back(e);
                pc_m[ptr_m] = br[5:0];
                ptr_m       = ptr_m + 2'd1;
            end
            if (config_write) begin
                if (config_addr[9:6] == IM_BASE[9:6]) begin
                    im_m[config_addr[5:0]] = config_data;
                end else if (config_addr[9:6] == OD_BASE[9:6]) begin
                    od_m[config_addr[5:0]] = config_data[11:0];
                end else if (config_addr[9:4] == BT_BASE[9:4]) begin
                    bt_m[config_addr[3:0]] = config_data[16:0];
                end
            end
        end
    end

    // --------------------
    // Comparison, away from the active edge
    // --------------------
    always @(negedge clock) begin
        expect_t want;
        if (out_valid === 1'b1) begin
            assert (expected.size() > 0)
            else fail_with("Output valid without a matching issue");
            want = expected.pop_front();
            assert (out_thread === want.thread)
            else mismatch("out_thread", out_thread, want.thread);
            assert (cancel === want.cancel) else mismatch("cancel", cancel, want.cancel);
            assert (alu_control === want.alu)
            else mismatch("alu_control", alu_control, want.alu);
            assert (dst === want.d) else mismatch("dst", dst, want.d);
            assert (src_a === want.a) else mismatch("src_a", src_a, want.a);
            assert (src_b === want.b) else mismatch("src_b", src_b, want.b);
            compared++;
        end else begin
            assert (out_valid === 1'b0) else fail_with("out_valid is unknown");
            assert (cancel === 1'b0) else mismatch("cancel", cancel, 0);
        end
    end

    // --------------------
    // Stimulus
    // --------------------
    initial begin
        int waited;
        void'($urandom(59));
        rst_n        = 1'b0;
        run          = 1'b0;
        config_write = 1'b0;
        config_addr  = '0;
        config_data  = '0;
        carryout     = 1'b0;
        overflow     = 1'b0;
        a_external   = 1'b0;
        b_external   = 1'b0;
        r_previous   = '0;
        repeat (2) tick();
        rst_n <= 1'b1;

        // Idle with run low, nothing may come out
        repeat (8) tick();
        for (int i = 0; i < 64; i++) begin
            write_config(IM_BASE + i, 32'($urandom));
        end
        for (int i = 0; i < 64; i++) begin
            write_config(OD_BASE + i, 32'($urandom));
        end
        tick();
        run <= 1'b1;

        // Straight-line counters, tables still disabled
        repeat (40) tick();

        // Each thread loops over its own sixteen words
        for (int t = 0; t < 4; t++) begin
            write_config(BT_BASE + t * 4, branch_word(1'b1, 1'b0, 0, t * 16 + 15, t * 16));
        end
        repeat (100) tick();

        // Conditional skip from 3 to 12, one condition code at a time
        for (int c = 0; c < 8; c++) begin
            for (int t = 0; t < 4; t++) begin
                write_config(BT_BASE + t * 4 + 1,
                             branch_word(1'b1, 1'b0, c, t * 16 + 3, t * 16 + 12));
            end
            repeat (128) tick();
        end

        // Two entries on one origin, the cancelling one has priority
        for (int t = 0; t < 4; t++) begin
            write_config(BT_BASE + t * 4 + 1, branch_word(1'b1, 1'b1, 0, t * 16 + 3, t * 16 + 8));
            write_config(BT_BASE + t * 4 + 2,
                         branch_word(1'b1, 1'b0, 0, t * 16 + 3, t * 16 + 10));
        end
        repeat (64) tick();

        // Instruction rewrites on the live path
        for (int t = 0; t < 4; t++) begin
            write_config(IM_BASE + t * 16 + 9, 32'($urandom));
        end
        repeat (64) tick();
        tick();
        run <= 1'b0;

        waited = 0;
        while (expected.size() > 0 && waited < DRAIN_LIMIT) begin
            tick();
            waited++;
        end
        if (expected.size() > 0) begin
            fail_with("Timeout waiting for the pipeline to drain");
        end
        tick();

        if (dut.u_checks.failures == 0 && compared > 0) begin
            $display("All checks passed");
            $finish;
        end else begin
            fail_with("Bound assertions failed or no outputs were compared");
        end
    end

endmodule

`default_nettype wire
